// File: rtl/hist_pkg.sv
`default_nettype none

package hist_pkg;

    // one event from the sensor front end
    // bin is sized for the widest bin address, modules use the low bits
    typedef struct packed {
        logic       valid;
        logic [7:0] bin;
    } hist_event_t;

    // command opcodes for the counter memory
    typedef enum logic [1:0] {
        BANK_NOP = 2'd0,
        BANK_INC = 2'd1,
        BANK_CLR = 2'd2
    } bank_op_e;

    // one memory command per cycle
    // for clears the bin field carries the flat word index in the bank
    typedef struct packed {
        bank_op_e   op;
        logic       bank;
        logic [7:0] pixel;
        logic [7:0] bin;
    } bank_cmd_t;

    typedef enum logic [1:0] {
        SEQ_INIT_CLEAR  = 2'd0,
        SEQ_COLLECT     = 2'd1,
        SEQ_DRAIN       = 2'd2,
        SEQ_FRAME_CLEAR = 2'd3
    } seq_state_e;

    // axi4-lite read address channel, host side
    typedef struct packed {
        logic        arvalid;
        logic [11:0] araddr;
    } axil_ar_t;

    // axi4-lite read data channel, slave side
    typedef struct packed {
        logic        rvalid;
        logic [31:0] rdata;
        logic [1:0]  rresp;
    } axil_r_t;

    // register map
    localparam logic [11:0] STATUS_ADDR   = 12'h000;
    localparam logic [11:0] BIN_BASE_ADDR = 12'h100;

    localparam logic [1:0] RESP_OKAY   = 2'b00;
    localparam logic [1:0] RESP_SLVERR = 2'b10;

endpackage

`default_nettype wire

// File: rtl/hist_sequencer.sv
`default_nettype none

module hist_sequencer (
    input  logic                 clk,
    input  logic                 res,
    input  hist_pkg::hist_event_t ev,
    input  logic                 frame_last,
    input  logic                 sweep_last,
    input  logic [7:0]           pixel_idx,
    input  logic [8:0]           sweep_addr,
    output logic                 ev_ready,
    output logic                 advance,
    output logic                 sweep_en,
    output logic                 frame_done,
    output logic                 fill_bank,
    output logic                 busy,
    output logic [15:0]          frame_count,
    output hist_pkg::bank_cmd_t  bank_cmd
);
    import hist_pkg::*;

    seq_state_e state;
    logic       accept;
    // second drain cycle marker
    logic       drain_cnt;

    // events only flow while collecting
    assign ev_ready = (state == SEQ_COLLECT);
    assign accept   = ev.valid && ev_ready;
    assign advance  = accept;
    assign sweep_en = (state == SEQ_INIT_CLEAR) || (state == SEQ_FRAME_CLEAR);
    assign busy     = !ev_ready;

    always_comb begin
        bank_cmd = '{op: BANK_NOP, bank: fill_bank, pixel: 8'd0, bin: 8'd0};
        if (accept) begin
            // increment in the fill bank, pixel from arrival order
            bank_cmd.op    = BANK_INC;
            bank_cmd.pixel = pixel_idx;
            bank_cmd.bin   = ev.bin;
        end else if (sweep_en) begin
            // sweep bank bit is relative to the fill bank
            bank_cmd.op   = BANK_CLR;
            bank_cmd.bank = fill_bank ^ sweep_addr[8];
            bank_cmd.bin  = sweep_addr[7:0];
        end
    end

    always_ff @(posedge clk or negedge res) begin
        if (!res) begin
            state       <= SEQ_INIT_CLEAR;
            drain_cnt   <= 1'b0;
            fill_bank   <= 1'b0;
            frame_count <= 16'd0;
            frame_done  <= 1'b0;
        end else begin
            frame_done <= 1'b0;
            case (state)
                SEQ_INIT_CLEAR: begin
                    if (sweep_last) begin
                        state <= SEQ_COLLECT;
                    end
                end
                SEQ_COLLECT: begin
                    if (accept && frame_last) begin
                        state     <= SEQ_DRAIN;
                        drain_cnt <= 1'b0;
                    end
                end
                SEQ_DRAIN: begin
                    // two cycles let the last increment reach memory
                    drain_cnt <= 1'b1;
                    if (drain_cnt) begin
                        state       <= SEQ_FRAME_CLEAR;
                        fill_bank   <= ~fill_bank;
                        frame_count <= frame_count + 16'd1;
                        frame_done  <= 1'b1;
                    end
                end
                SEQ_FRAME_CLEAR: begin
                    if (sweep_last) begin
                        state <= SEQ_COLLECT;
                    end
                end
                default: begin
                    state <= SEQ_INIT_CLEAR;
                end
            endcase
        end
    end

    // a frame clear only ever wipes the bank about to be filled
    assert property (@(posedge clk) disable iff (!res)
        (state == SEQ_FRAME_CLEAR) |-> (bank_cmd.bank == fill_bank));

endmodule

`default_nettype wire

// File: rtl/hist_position_counter.sv
`default_nettype none

module hist_position_counter #(
    parameter int num_pixels       = 4,
    parameter int num_bins         = 16,
    parameter int inputs_per_pixel = 3,
    parameter int acqs_per_frame   = 2
) (
    input  logic       clk,
    input  logic       res,
    input  logic       advance,
    input  logic       sweep_en,
    output logic [7:0] pixel_idx,
    output logic       frame_last,
    output logic       sweep_last,
    output logic [8:0] sweep_addr
);
    localparam int words = num_pixels * num_bins;

    logic [7:0] input_cnt;
    logic [7:0] acq_cnt;
    logic [7:0] sweep_idx;
    logic       sweep_bank;
    // first sweep after reset covers both banks
    logic       init_phase;
    logic       input_last;
    logic       pixel_last;
    logic       acq_last;
    logic       idx_last;

    assign input_last = (input_cnt == 8'(inputs_per_pixel - 1));
    assign pixel_last = (pixel_idx == 8'(num_pixels - 1));
    assign acq_last   = (acq_cnt == 8'(acqs_per_frame - 1));
    assign frame_last = input_last && pixel_last && acq_last;

    assign idx_last   = (sweep_idx == 8'(words - 1));
    assign sweep_last = idx_last && (sweep_bank || !init_phase);
    assign sweep_addr = {sweep_bank, sweep_idx};

    // input, pixel and acquisition counts, wrap at frame end
    always_ff @(posedge clk or negedge res) begin
        if (!res) begin
            input_cnt <= 8'd0;
            pixel_idx <= 8'd0;
            acq_cnt   <= 8'd0;
        end else if (advance) begin
            if (!input_last) begin
                input_cnt <= input_cnt + 8'd1;
            end else begin
                input_cnt <= 8'd0;
                if (!pixel_last) begin
                    pixel_idx <= pixel_idx + 8'd1;
                end else begin
                    pixel_idx <= 8'd0;
                    acq_cnt   <= acq_last ? 8'd0 : acq_cnt + 8'd1;
                end
            end
        end
    end

    // clear sweep over one bank, or both during init
    always_ff @(posedge clk or negedge res) begin
        if (!res) begin
            sweep_idx  <= 8'd0;
            sweep_bank <= 1'b0;
            init_phase <= 1'b1;
        end else if (sweep_en) begin
            if (!idx_last) begin
                sweep_idx <= sweep_idx + 8'd1;
            end else begin
                sweep_idx <= 8'd0;
                if (init_phase && !sweep_bank) begin
                    sweep_bank <= 1'b1;
                end else begin
                    sweep_bank <= 1'b0;
                    init_phase <= 1'b0;
                end
            end
        end
    end

    // counting and clearing never overlap
    assert property (@(posedge clk) disable iff (!res) !(advance && sweep_en));

endmodule

`default_nettype wire

// File: rtl/hist_bank_mem.sv
`default_nettype none

module hist_bank_mem #(
    parameter int num_pixels  = 4,
    parameter int num_bins    = 16,
    parameter int count_width = 16
) (
    input  logic                clk,
    input  logic                res,
    input  hist_pkg::bank_cmd_t bank_cmd,
    input  logic                read_bank,
    input  logic [7:0]          rd_addr,
    output logic [31:0]         rd_data
);
    import hist_pkg::*;

    localparam int words  = num_pixels * num_bins;
    localparam int addr_w = $clog2(2 * words);
    // num_bins is a power of two
    localparam logic [7:0] bin_mask = 8'(num_bins - 1);

    logic [count_width-1:0] mem [2*words];

    logic [addr_w-1:0]      cmd_addr;
    logic [7:0]             inc_idx;

    // stage 1, counter read
    logic                   s1_valid;
    logic [addr_w-1:0]      s1_addr;
    logic                   s1_bank;
    logic [count_width-1:0] s1_count;

    // stage 2, write back
    logic                   s2_valid;
    logic [addr_w-1:0]      s2_addr;
    logic                   s2_bank;
    logic [count_width-1:0] s2_count;
    logic [count_width-1:0] s2_next;

    // bank and index within the bank to a word address
    function automatic logic [addr_w-1:0] word_addr(input logic bank, input logic [7:0] idx);
        return addr_w'(bank) * addr_w'(words) + addr_w'(idx);
    endfunction

    assign inc_idx = 8'(int'(bank_cmd.pixel) * num_bins) + (bank_cmd.bin & bin_mask);

    // clears carry the flat index directly
    assign cmd_addr = (bank_cmd.op == BANK_CLR) ? word_addr(bank_cmd.bank, bank_cmd.bin)
                                                : word_addr(bank_cmd.bank, inc_idx);

    // saturating increment
    assign s2_next = (&s2_count) ? s2_count : s2_count + 1'b1;

    // forward the pending write to a same-address successor
    assign s1_count = (s2_valid && (s2_addr == s1_addr)) ? s2_next : mem[s1_addr];

    always_ff @(posedge clk or negedge res) begin
        if (!res) begin
            s1_valid <= 1'b0;
            s2_valid <= 1'b0;
        end else begin
            s1_valid <= (bank_cmd.op == BANK_INC);
            s2_valid <= s1_valid;
        end
    end

    always_ff @(posedge clk) begin
        s1_addr  <= cmd_addr;
        s1_bank  <= bank_cmd.bank;
        s2_addr  <= s1_addr;
        s2_bank  <= s1_bank;
        s2_count <= s1_count;
        // clears never overlap with increments in flight
        if (bank_cmd.op == BANK_CLR) begin
            mem[cmd_addr] <= '0;
        end else if (s2_valid) begin
            mem[s2_addr] <= s2_next;
        end
    end

    // readout port, read bank only, zero extended
    always_ff @(posedge clk) begin
        rd_data <= 32'(mem[word_addr(read_bank, rd_addr)]);
    end

    // a bank swap never happens with an increment still in the pipe
    assert property (@(posedge clk) disable iff (!res) s2_valid |-> (s2_bank != read_bank));

endmodule

`default_nettype wire

// File: rtl/axil_hist_reader.sv
`default_nettype none

module axil_hist_reader #(
    parameter int num_pixels = 4,
    parameter int num_bins   = 16
) (
    input  logic               clk,
    input  logic               res,
    input  hist_pkg::axil_ar_t ar,
    output logic               arready,
    output hist_pkg::axil_r_t  r,
    input  logic               rready,
    input  logic               fill_bank,
    input  logic               busy,
    input  logic [15:0]        frame_count,
    output logic [7:0]         rd_addr,
    input  logic [31:0]        rd_data
);
    import hist_pkg::*;

    localparam int words = num_pixels * num_bins;
    localparam logic [11:0] bin_end = BIN_BASE_ADDR + 12'(4 * words);

    logic        hs;
    logic        addr_is_status;
    logic        addr_is_bin;
    logic [9:0]  bin_offset;
    logic [31:0] status;

    // read launched, data assembled next cycle
    logic        pend;
    logic        pend_status;
    logic        pend_bin;

    logic        rvalid_q;
    logic [31:0] rdata_q;
    logic [1:0]  rresp_q;

    assign hs = ar.arvalid && arready;

    // address decode
    assign addr_is_status = (ar.araddr == STATUS_ADDR);
    assign addr_is_bin    = (ar.araddr >= BIN_BASE_ADDR) && (ar.araddr < bin_end)
                            && (ar.araddr[1:0] == 2'b00);

    // memory read starts in the handshake cycle
    assign bin_offset = 10'(ar.araddr - BIN_BASE_ADDR);
    assign rd_addr    = bin_offset[9:2];

    assign status = {14'd0, busy, fill_bank, frame_count};

    assign r = '{rvalid: rvalid_q, rdata: rdata_q, rresp: rresp_q};

    always_ff @(posedge clk or negedge res) begin
        if (!res) begin
            arready  <= 1'b0;
            pend     <= 1'b0;
            rvalid_q <= 1'b0;
        end else begin
            // one read outstanding at a time
            arready <= !hs && !pend && !(rvalid_q && !rready);
            pend    <= hs;
            if (pend) begin
                rvalid_q <= 1'b1;
            end else if (rready) begin
                rvalid_q <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (hs) begin
            pend_status <= addr_is_status;
            pend_bin    <= addr_is_bin;
        end
        if (pend) begin
            if (pend_status) begin
                rdata_q <= status;
                rresp_q <= RESP_OKAY;
            end else if (pend_bin) begin
                rdata_q <= rd_data;
                rresp_q <= RESP_OKAY;
            end else begin
                // unmapped address
                rdata_q <= 32'd0;
                rresp_q <= RESP_SLVERR;
            end
        end
    end

    // response held while the host stalls
    assert property (@(posedge clk) disable iff (!res)
        (r.rvalid && !rready) |=> (r.rvalid && $stable(r.rdata)));

endmodule

`default_nettype wire

// File: rtl/hist_builder_top.sv
`default_nettype none

module hist_builder_top #(
    parameter int num_bins         = 16,
    parameter int num_pixels       = 4,
    parameter int inputs_per_pixel = 3,
    parameter int acqs_per_frame   = 2,
    parameter int count_width      = 16
) (
    input  logic                  clk,
    input  logic                  res,
    input  hist_pkg::hist_event_t ev,
    output logic                  ev_ready,
    output logic                  frame_done,
    input  hist_pkg::axil_ar_t    ar,
    output logic                  arready,
    output hist_pkg::axil_r_t     r,
    input  logic                  rready
);
    import hist_pkg::*;

    bank_cmd_t   bank_cmd;
    logic        advance;
    logic        sweep_en;
    logic        frame_last;
    logic        sweep_last;
    logic        fill_bank;
    logic        busy;
    logic [7:0]  pixel_idx;
    logic [8:0]  sweep_addr;
    logic [15:0] frame_count;
    logic [7:0]  rd_addr;
    logic [31:0] rd_data;

    hist_sequencer u_seq (
        .clk         (clk),
        .res         (res),
        .ev          (ev),
        .frame_last  (frame_last),
        .sweep_last  (sweep_last),
        .pixel_idx   (pixel_idx),
        .sweep_addr  (sweep_addr),
        .ev_ready    (ev_ready),
        .advance     (advance),
        .sweep_en    (sweep_en),
        .frame_done  (frame_done),
        .fill_bank   (fill_bank),
        .busy        (busy),
        .frame_count (frame_count),
        .bank_cmd    (bank_cmd)
    );

    hist_position_counter #(
        .num_pixels       (num_pixels),
        .num_bins         (num_bins),
        .inputs_per_pixel (inputs_per_pixel),
        .acqs_per_frame   (acqs_per_frame)
    ) u_pos (
        .clk        (clk),
        .res        (res),
        .advance    (advance),
        .sweep_en   (sweep_en),
        .pixel_idx  (pixel_idx),
        .frame_last (frame_last),
        .sweep_last (sweep_last),
        .sweep_addr (sweep_addr)
    );

    // the host reads the bank that is not being filled
    hist_bank_mem #(
        .num_pixels  (num_pixels),
        .num_bins    (num_bins),
        .count_width (count_width)
    ) u_mem (
        .clk       (clk),
        .res       (res),
        .bank_cmd  (bank_cmd),
        .read_bank (~fill_bank),
        .rd_addr   (rd_addr),
        .rd_data   (rd_data)
    );

    axil_hist_reader #(
        .num_pixels (num_pixels),
        .num_bins   (num_bins)
    ) u_reader (
        .clk         (clk),
        .res         (res),
        .ar          (ar),
        .arready     (arready),
        .r           (r),
        .rready      (rready),
        .fill_bank   (fill_bank),
        .busy        (busy),
        .frame_count (frame_count),
        .rd_addr     (rd_addr),
        .rd_data     (rd_data)
    );

endmodule

`default_nettype wire

// File: sim/hist_builder_tb.sv
`default_nettype none

module hist_builder_tb;
    import hist_pkg::*;

    localparam int max_records = 512;
    // generous budget, covers the 128 cycle init clear and the frame clears
    localparam int cycles_per_record = 300;

    // record opcodes, bits 31:28
    localparam logic [3:0] op_name  = 4'h1;
    localparam logic [3:0] op_event = 4'h2;
    localparam logic [3:0] op_wait  = 4'h3;
    localparam logic [3:0] op_read  = 4'h4;
    localparam logic [3:0] op_end   = 4'hf;

    logic        clk;
    logic        res;
    hist_event_t ev;
    logic        ev_ready;
    logic        frame_done;
    axil_ar_t    ar;
    logic        arready;
    axil_r_t     r;
    logic        rready;

    logic [31:0] tests [max_records];
    int          n_records;
    // tag of the current test section
    int          test_tag;
    logic [31:0] lfsr;

    hist_builder_top dut0 (.*);

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    // all driving and sampling happens 1 unit after the rising edge
    task automatic tick();
        @(posedge clk);
        #1;
    endtask

    // fibonacci lfsr, taps 32 22 2 1, one step per bit
    function automatic logic take_bit();
        lfsr = {lfsr[30:0], lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0]};
        return lfsr[0];
    endfunction

    task automatic check(input string what, input logic [31:0] exp, input logic [31:0] act);
        if (exp !== act) begin
            $display("MISMATCH test %0d %s expected %h actual %h", test_tag, what, exp, act);
            $display("RESULT: FAIL");
            $fatal(1, "stopped at the first error");
        end
    endtask

    task automatic send_event(input logic [7:0] bin, input logic no_gap);
        logic gap;
        gap = 1'b0;
        if (!no_gap) begin
            gap = take_bit();
        end
        // random idle cycles before the event
        while (gap) begin
            tick();
            gap = take_bit();
        end
        ev.valid = 1'b1;
        ev.bin   = bin;
        // ev_ready only moves on a clock edge
        while (!ev_ready) tick();
        tick();
        // a no-gap successor raises valid again at this same time
        ev.valid = 1'b0;
    endtask

    // called right after the last event of a frame
    // two drain cycles, then frame_done high for one cycle
    task automatic wait_frame();
        int n;
        n = 0;
        while (!frame_done) begin
            tick();
            n++;
        end
        check("frame_done delay", 32'd2, 32'(n));
        tick();
        check("frame_done width", 32'd0, 32'(frame_done));
    endtask

    task automatic axi_read(input logic [11:0] addr, input logic [31:0] exp_rec);
        logic        stall_free;
        logic        got;
        logic [31:0] data;
        logic [1:0]  resp;
        int          lat;
        got  = 1'b0;
        lat  = 0;
        data = 32'd0;
        resp = 2'd0;
        ar.arvalid = 1'b1;
        ar.araddr  = addr;
        while (!arready) tick();
        tick();
        ar.arvalid = 1'b0;
        // random rready, the response must wait for it
        while (!got) begin
            stall_free = take_bit();
            rready     = stall_free;
            if (!r.rvalid) begin
                lat++;
            end else if (rready) begin
                got  = 1'b1;
                data = r.rdata;
                resp = r.rresp;
            end
            tick();
        end
        rready = 1'b0;
        // one idle cycle between address handshake and rvalid
        check("read latency", 32'd1, 32'(lat));
        // a second response would show up here
        check("rvalid after handshake", 32'd0, 32'(r.rvalid));
        check("rresp", 32'(exp_rec[29:28]), 32'(resp));
        check("rdata", {4'h0, exp_rec[27:0]}, data);
    endtask

    initial begin
        int          pc;
        logic [31:0] rec;
        res       = 1'b0;
        ev        = '0;
        ar        = '0;
        rready    = 1'b0;
        lfsr      = 32'hfdb4;
        test_tag  = 0;
        pc        = 0;
        n_records = 0;
        $readmemh("sim/hist_tests.mem", tests);
        while (n_records < max_records && tests[n_records][31:28] !== op_end) n_records++;
        if (n_records == max_records) begin
            $display("the tests file has no end record");
            $display("RESULT: FAIL");
            $fatal(1, "bad tests file");
        end
        repeat (16) @(posedge clk);
        #1;
        res = 1'b1;
        while (pc < n_records) begin
            rec = tests[pc];
            case (rec[31:28])
                op_name:  test_tag = int'(rec[15:0]);
                op_event: send_event(rec[7:0], rec[8]);
                op_wait:  wait_frame();
                op_read: begin
                    // next record holds the expected response
                    axi_read(rec[11:0], tests[pc + 1]);
                    pc++;
                end
                default: begin
                    $display("unknown record %h at index %0d", rec, pc);
                    $display("RESULT: FAIL");
                    $fatal(1, "bad tests file");
                end
            endcase
            pc++;
        end
        $display("RESULT: PASS");
        $finish;
    end

    // watchdog, budget scales with the number of records
    initial begin
        wait (n_records > 0);
        repeat (n_records * cycles_per_record) @(posedge clk);
        $display("timeout, the run took more than %0d cycles", n_records * cycles_per_record);
        $display("RESULT: FAIL");
        $fatal(1, "watchdog expired");
    end

endmodule

`default_nettype wire

// File: sim/hist_tests.mem
// record op[31:28] arg[27:0]: 1 name tag, 2 event bin (bit 8 no gap), 3 wait frame,
// 4 read addr[11:0] then expected rresp[29:28] rdata[27:0], f end
10000001
// frame 1 acq 0, pixel 0 three same-bin events without gaps
20000105 20000105 20000105 20000002 20000007 20000002
2000000f 20000000 2000000f 20000009 20000009 20000003
// frame 1 acq 1
20000001 20000004 20000001 20000107 20000107 20000107
20000000 20000000 2000000f 20000003 2000000c 20000009
30000000
// p0 b1, p0 b4, p1 b2, p2 b15
40000104 00000002 40000110 00000001
40000148 00000002 400001bc 00000003
// p2 b0, p3 b9, p3 b3, p3 b12, p0 b0 untouched
40000180 00000003 400001e4 00000003
400001cc 00000002 400001f0 00000001
40000100 00000000
// forwarding, p0 b5 and p1 b7
10000002
40000114 00000003 4000015c 00000004
// status in collect, fill bank 1, one frame
10000004
20000006 20000006 20000006 20000002 20000002 2000000b
40000000 00010001
// unmapped and misaligned addresses
10000005
40000200 20000000 40000102 20000000
// rest of frame 2
20000004 20000004 20000004 20000000 20000001 20000000
20000006 20000008 20000008 2000000b 2000000b 20000002
20000004 2000000d 2000000d 20000001 20000001 20000001
30000000
// frame 2 only, status busy in frame clear, fill bank 0, two frames
10000003
40000000 00020002
40000118 00000004 40000120 00000002
40000114 00000000 40000148 00000003
4000016c 00000003 4000015c 00000000
40000190 00000004 400001b4 00000002
400001c0 00000002 400001c4 00000004
400001e4 00000000
// repeated reads under rready stalls
10000006
40000118 00000004 40000118 00000004
400001c4 00000004 40000190 00000004
40000300 20000000 400001c0 00000002
f0000000

// File: build.f
rtl/hist_pkg.sv
rtl/hist_sequencer.sv
rtl/hist_position_counter.sv
rtl/hist_bank_mem.sv
rtl/axil_hist_reader.sv
rtl/hist_builder_top.sv
sim/hist_builder_tb.sv

// File: Makefile
.PHONY: sim clean

sim:
	verilator --binary --timing --assert -Wno-fatal -f build.f \
		--top-module hist_builder_tb -Mdir obj_dir
	./obj_dir/Vhist_builder_tb

clean:
	rm -rf obj_dir
